//--- include/icache_settings.svh
// Instruction cache geometry and reset PC, included by the package, the RTL and the testbench
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Ways per set
`define ICACHE_WAYS 2

// Number of sets
`define ICACHE_SETS 64

// Line size in bytes
`define ICACHE_LINE_BYTES 32

// 64-bit beats per line, one AR burst fills a whole line
`define ICACHE_BEATS 4

// First fetch address after reset
`define ICACHE_RESET_PC 32'h8000_0000

`endif

//--- src/icache_pkg.sv
// Shared types of the fetch front, referenced by scoped name from every RTL module
`include "icache_settings.svh"

package icache_pkg;

	// Byte address on the fetch and memory side
	typedef logic [31:0] addr_t;

	// Fetch word and memory read beat
	typedef logic [63:0] word_t;

	// Address bits above set index and line offset
	typedef logic [31-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_BYTES):0] tag_t;

	// Set number
	typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

	// One bit per way, used for hits, valids and the refill way
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	// Cache controller states
	typedef enum logic [1:0] {st_idle, st_lookup, st_refill, st_fence} ic_state_e;

endpackage

//--- src/victim_sel.sv
// Refill way choice for the instruction cache, first invalid way else a pseudo-random one
`timescale 1ns/1ps
`include "icache_settings.svh"

module victim_sel (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  icache_pkg::way_mask_t set_valid,
	output icache_pkg::way_mask_t victim
);

	localparam int WAY_W = $clog2(`ICACHE_WAYS);

	logic [15:0] lfsr;

	// Fibonacci LFSR, taps 16 14 13 11, free running
	always_ff @(posedge CLK) begin
		if (!rst_n) lfsr <= 16'hace1;
		else lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	always_comb begin
		// Set full, random way
		victim = icache_pkg::way_mask_t'(1) << lfsr[WAY_W-1:0];
		// Lowest invalid way wins, scan from the top so the last hit is lowest
		for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
			if (!set_valid[w]) victim = icache_pkg::way_mask_t'(1) << w;
		end
	end

endmodule

//--- src/icache_mem.sv
// Tag and data storage of the instruction cache, one registered read port and per-way beat writes
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_mem (
	input  logic                                CLK,
	input  logic                                rd_en,
	input  icache_pkg::way_mask_t               wr_en,
	input  icache_pkg::index_t                  index,
	input  logic [$clog2(`ICACHE_BEATS)-1:0]    offset,
	input  icache_pkg::tag_t                    wr_tag,
	input  icache_pkg::word_t                   wr_data,
	output icache_pkg::tag_t                    rd_tag0,
	output icache_pkg::tag_t                    rd_tag1,
	output icache_pkg::word_t                   rd_data0,
	output icache_pkg::word_t                   rd_data1
);

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_pkg::tag_t  tag_arr  [`ICACHE_SETS];
		// Line data, addressed by set and beat
		icache_pkg::word_t data_arr [`ICACHE_SETS*`ICACHE_BEATS];
		icache_pkg::tag_t  rd_tag_q;
		icache_pkg::word_t rd_data_q;

		always_ff @(posedge CLK) begin
			if (wr_en[w]) begin
				data_arr[{index, offset}] <= wr_data;
				// Tag goes in with beat 0 of the line
				if (offset == '0) tag_arr[index] <= wr_tag;
			end
			if (rd_en) begin
				rd_tag_q  <= tag_arr[index];
				rd_data_q <= data_arr[{index, offset}];
			end
		end
	end

	assign rd_tag0  = g_way[0].rd_tag_q;
	assign rd_tag1  = g_way[1].rd_tag_q;
	assign rd_data0 = g_way[0].rd_data_q;
	assign rd_data1 = g_way[1].rd_data_q;

endmodule

//--- src/icache.sv
// Two-way L1 instruction cache controller, looks up fetch_pc and refills lines by AR/R bursts
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache (
	input  logic              CLK,
	input  logic              rst_n,
	input  icache_pkg::addr_t fetch_pc,
	output logic              pc_ready,
	input  logic              flush,
	input  logic              fence,
	output logic              fence_end,
	output logic              iq_valid,
	output icache_pkg::addr_t iq_pc,
	output icache_pkg::word_t iq_instr,
	input  logic              iq_ready,
	output icache_pkg::addr_t mem_araddr,
	output logic              mem_arvalid,
	input  logic              mem_arready,
	input  icache_pkg::word_t mem_rdata,
	input  logic              mem_rlast,
	input  logic              mem_rvalid,
	output logic              mem_rready
);

	localparam int OFF_W  = $clog2(`ICACHE_LINE_BYTES);
	localparam int IDX_W  = $clog2(`ICACHE_SETS);
	localparam int BEAT_W = $clog2(`ICACHE_BEATS);

	icache_pkg::ic_state_e state, state_nxt;
	icache_pkg::addr_t     req_addr;
	icache_pkg::tag_t      req_tag, rd_tag0, rd_tag1;
	icache_pkg::index_t    req_index, mem_index;
	icache_pkg::word_t     rd_data0, rd_data1, hit_data;
	icache_pkg::way_mask_t valid_q [`ICACHE_SETS];
	icache_pkg::way_mask_t set_valid, hit_mask, victim, fill_way, wr_en;
	logic [BEAT_W-1:0]     beat_cnt, mem_offset;
	logic                  start, hit, beat_fire, beat_hit, last_fire;
	logic                  kill_q, arvalid_q, rready_q;

	// Request fields, latched at lookup start
	assign req_tag   = req_addr[31:OFF_W+IDX_W];
	assign req_index = req_addr[OFF_W +: IDX_W];

	// New lookup only with queue room and no redirect pending
	assign start = (state == icache_pkg::st_idle) & iq_ready & ~flush & ~fence;

	// Hit compare against registered tags
	assign set_valid   = valid_q[req_index];
	assign hit_mask[0] = set_valid[0] & (rd_tag0 == req_tag);
	assign hit_mask[1] = set_valid[1] & (rd_tag1 == req_tag);
	assign hit         = |hit_mask;
	assign hit_data    = hit_mask[1] ? rd_data1 : rd_data0;

	// Refill beat accounting
	assign beat_fire = (state == icache_pkg::st_refill) & mem_rvalid & rready_q;
	assign last_fire = beat_fire & mem_rlast;
	// Critical word is the beat matching the requested offset
	assign beat_hit  = beat_fire & (beat_cnt == req_addr[3 +: BEAT_W]) & ~kill_q & ~flush;

	assign pc_ready  = ((state == icache_pkg::st_lookup) & hit & ~flush) | beat_hit;
	assign fence_end = (state == icache_pkg::st_fence);

	// Memory side, always the line base
	assign mem_araddr  = {req_addr[31:OFF_W], {OFF_W{1'b0}}};
	assign mem_arvalid = arvalid_q;
	assign mem_rready  = rready_q;

	// Arrays follow the refill pointer during a burst, else the live fetch_pc
	assign mem_index  = (state == icache_pkg::st_refill) ? req_index : fetch_pc[OFF_W +: IDX_W];
	assign mem_offset = (state == icache_pkg::st_refill) ? beat_cnt : fetch_pc[3 +: BEAT_W];
	assign wr_en      = fill_way & {`ICACHE_WAYS{beat_fire}};

	always_comb begin
		state_nxt = state;
		case (state)
			icache_pkg::st_idle: begin
				if (fence) state_nxt = icache_pkg::st_fence;
				else if (start) state_nxt = icache_pkg::st_lookup;
			end
			icache_pkg::st_lookup: begin
				// Flush drops the request before any burst starts
				if (flush | hit) state_nxt = icache_pkg::st_idle;
				else state_nxt = icache_pkg::st_refill;
			end
			icache_pkg::st_refill: begin
				if (last_fire) state_nxt = icache_pkg::st_idle;
			end
			default: state_nxt = icache_pkg::st_idle;
		endcase
	end

	// Control state
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state     <= icache_pkg::st_idle;
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			kill_q    <= 1'b0;
			beat_cnt  <= '0;
			iq_valid  <= 1'b0;
		end else begin
			state    <= state_nxt;
			iq_valid <= pc_ready;
			if ((state == icache_pkg::st_lookup) && (state_nxt == icache_pkg::st_refill)) begin
				// Miss, one AR per line
				arvalid_q <= 1'b1;
				rready_q  <= 1'b1;
				kill_q    <= 1'b0;
				beat_cnt  <= '0;
			end else begin
				if (arvalid_q && mem_arready) arvalid_q <= 1'b0;
				if (last_fire) rready_q <= 1'b0;
				// Burst still lands in the array, only delivery is dropped
				if ((state == icache_pkg::st_refill) && flush) kill_q <= 1'b1;
				if (beat_fire) beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// Valid bits, whole cache cleared by fence
	always_ff @(posedge CLK) begin
		if (!rst_n || (state == icache_pkg::st_fence)) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (last_fire) begin
			valid_q[req_index] <= valid_q[req_index] | fill_way;
		end
	end

	// Request and queue payload
	always_ff @(posedge CLK) begin
		if (start) req_addr <= fetch_pc;
		if (state == icache_pkg::st_lookup) fill_way <= victim;
		if (pc_ready) begin
			iq_pc    <= req_addr;
			iq_instr <= (state == icache_pkg::st_refill) ? mem_rdata : hit_data;
		end
	end

	icache_mem icache_mem_i (
		.CLK      (CLK),
		.rd_en    (start),
		.wr_en    (wr_en),
		.index    (mem_index),
		.offset   (mem_offset),
		.wr_tag   (req_tag),
		.wr_data  (mem_rdata),
		.rd_tag0  (rd_tag0),
		.rd_tag1  (rd_tag1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1)
	);

	victim_sel victim_sel_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.set_valid (set_valid),
		.victim    (victim)
	);

	// AR must stay up with a steady address until the memory takes it
	a_ar_hold: assert property (
		@(posedge CLK) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr)
	) else $error("mem_arvalid or mem_araddr changed before mem_arready");

	// Same line never lives in both ways
	a_one_hit: assert property (
		@(posedge CLK) disable iff (!rst_n)
		(state == icache_pkg::st_lookup) |-> $onehot0(hit_mask)
	) else $error("more than one way hit");

endmodule

//--- src/pc_gen.sv
// Fetch address register, steps by one 64-bit word per delivered fetch and loads flush targets
`timescale 1ns/1ps
`include "icache_settings.svh"

module pc_gen (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              flush,
	input  icache_pkg::addr_t flush_pc,
	input  logic              pc_ready,
	output icache_pkg::addr_t fetch_pc
);

	// Flush wins over a word delivered in the same cycle
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			fetch_pc <= `ICACHE_RESET_PC;
		end else if (flush) begin
			fetch_pc <= flush_pc;
		end else if (pc_ready) begin
			// Next sequential word, 8 bytes on
			fetch_pc <= fetch_pc + 32'd8;
		end
	end

	// Redirect targets from the pipeline must keep word alignment
	a_pc_aligned: assert property (
		@(posedge CLK) disable iff (!rst_n)
		fetch_pc[2:0] == 3'b000
	) else $error("fetch_pc not 8-byte aligned");

endmodule

//--- src/fetch_top.sv
// Fetch front top level, joins the PC generator and the L1 instruction cache to memory and queue
`timescale 1ns/1ps

module fetch_top (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               flush,
	input  icache_pkg::addr_t  flush_pc,
	input  logic               fence,
	output logic               fence_end,
	output logic               iq_valid,
	output icache_pkg::addr_t  iq_pc,
	output icache_pkg::word_t  iq_instr,
	input  logic               iq_ready,
	output icache_pkg::addr_t  mem_araddr,
	output logic               mem_arvalid,
	input  logic               mem_arready,
	input  icache_pkg::word_t  mem_rdata,
	input  logic               mem_rlast,
	input  logic               mem_rvalid,
	output logic               mem_rready
);

	// Request from PC generator, accepted by the cache one word at a time
	icache_pkg::addr_t fetch_pc;
	logic              pc_ready;

	pc_gen pc_gen_i (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.flush    (flush),
		.flush_pc (flush_pc),
		.pc_ready (pc_ready),
		.fetch_pc (fetch_pc)
	);

	icache icache_i (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.fetch_pc    (fetch_pc),
		.pc_ready    (pc_ready),
		.flush       (flush),
		.fence       (fence),
		.fence_end   (fence_end),
		.iq_valid    (iq_valid),
		.iq_pc       (iq_pc),
		.iq_instr    (iq_instr),
		.iq_ready    (iq_ready),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rlast   (mem_rlast),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready)
	);

endmodule

//--- test/tb_clk_gen.sv
// Testbench clock and reset source, 40 ns clock with reset held low for the first 3 cycles
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD = 40.0
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2.0) CLK = ~CLK;
	end

	// Synchronous reset, released just after the third rising edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge CLK);
		#1 rst_n = 1'b1;
	end

endmodule

//--- test/tb_mem_model.sv
// Burst read memory for the fetch testbench, answers each AR with 4 beats and random stalls
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_mem_model #(
	parameter logic [31:0] SEED = 32'hbf37_828e
) (
	input  logic        CLK,
	input  logic        rst_n,
	input  logic [31:0] mem_araddr,
	input  logic        mem_arvalid,
	output logic        mem_arready,
	output logic [63:0] mem_rdata,
	output logic        mem_rlast,
	output logic        mem_rvalid,
	input  logic        mem_rready
);

	integer      seed;
	logic [31:0] base;
	logic [31:0] ar_addr;
	int          beat;
	logic        busy;
	logic        ar_fire;
	logic        r_fire;

	// Memory contents, every bit of the address shows up in the word
	function automatic logic [63:0] word_at(input logic [31:0] addr);
		return {~addr, addr ^ 32'h5a5a_c3c3};
	endfunction

	initial begin
		seed        = SEED;
		busy        = 1'b0;
		beat        = 0;
		base        = '0;
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_rlast   = 1'b0;
		mem_rdata   = '0;
	end

	always @(posedge CLK) begin
		// Handshakes as seen at the edge
		ar_fire = mem_arvalid & mem_arready;
		r_fire  = mem_rvalid & mem_rready;
		ar_addr = mem_araddr;
		#1;
		if (!rst_n) begin
			busy        = 1'b0;
			mem_arready = 1'b0;
			mem_rvalid  = 1'b0;
			mem_rlast   = 1'b0;
		end else begin
			if (r_fire) begin
				beat = beat + 1;
				if (beat == `ICACHE_BEATS) busy = 1'b0;
			end
			if (ar_fire) begin
				base = ar_addr;
				beat = 0;
				busy = 1'b1;
			end
			// One burst outstanding at a time
			mem_arready = !busy && (($random(seed) & 3) != 0);
			mem_rvalid  = busy && (($random(seed) & 3) != 0);
			mem_rdata   = word_at(base + 32'(8 * beat));
			mem_rlast   = busy && (beat == `ICACHE_BEATS - 1);
		end
	end

endmodule

//--- test/tb_fetch.sv
// Fetch front testbench top, applies a redirect and fence table and checks every queued word
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_fetch;

	localparam int TIMEOUT = 4000;

	// Table row: fence first, optional redirect, redirect held for a pending miss,
	// words to wait for, iq_ready mode
	// Mode 0 holds iq_ready low, 1 keeps it high, 2 toggles it at random
	typedef struct packed {
		logic        do_fence;
		logic        do_flush;
		logic        on_miss;
		logic [31:0] target;
		logic [7:0]  count;
		logic [1:0]  mode;
	} row_t;

	// Lines stay in two 2 KB windows so no set ever holds more than two tags
	row_t rows [7] = '{
		'{1'b0, 1'b0, 1'b0, 32'h0,         8'd12, 2'd1},
		'{1'b0, 1'b1, 1'b1, 32'h8000_0800, 8'd8,  2'd1},
		'{1'b0, 1'b1, 1'b0, 32'h8000_0000, 8'd12, 2'd1},
		'{1'b1, 1'b1, 1'b0, 32'h8000_0020, 8'd8,  2'd1},
		'{1'b0, 1'b1, 1'b1, 32'h8000_0810, 8'd10, 2'd2},
		'{1'b1, 1'b1, 1'b0, 32'h8000_0100, 8'd20, 2'd2},
		'{1'b0, 1'b1, 1'b0, 32'h8000_0008, 8'd6,  2'd2}
	};

	logic        CLK, rst_n, flush, fence, fence_end, iq_valid, iq_ready;
	logic        mem_arvalid, mem_arready, mem_rlast, mem_rvalid, mem_rready;
	logic [31:0] flush_pc, iq_pc, mem_araddr;
	logic [63:0] iq_instr, mem_rdata;

	integer      seed;
	logic [1:0]  ready_mode;
	logic [31:0] exp_pc;
	int          errors, words, refills, fence_ends, fences_sent, first, waited;
	bit          in_burst;
	bit          resident [int unsigned];

	tb_clk_gen clk_gen_i (.CLK(CLK), .rst_n(rst_n));

	tb_mem_model mem_model_i (
		.CLK(CLK), .rst_n(rst_n), .mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready), .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
	);

	fetch_top fetch_top_i (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .flush_pc(flush_pc), .fence(fence),
		.fence_end(fence_end), .iq_valid(iq_valid), .iq_pc(iq_pc), .iq_instr(iq_instr),
		.iq_ready(iq_ready), .mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready), .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
	);

	// Expected memory word, same rule the memory model stores
	function automatic logic [63:0] expected_word(input logic [31:0] addr);
		return {~addr, addr ^ 32'h5a5a_c3c3};
	endfunction

	task automatic give_up(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	// Queue side readiness, changed a little after each edge
	always @(posedge CLK) begin
		#1;
		if (ready_mode == 2'd2) iq_ready = ($random(seed) & 1) == 1;
		else iq_ready = (ready_mode == 2'd1);
	end

	// Monitor of queue words, AR transfers, read channel ready and fence pulses
	always @(posedge CLK) begin
		if (rst_n) begin
			if (iq_valid) begin
				words++;
				if (iq_pc !== exp_pc) begin
					errors++;
					$display("ERR %0t: iq_pc %h, expected %h", $time, iq_pc, exp_pc);
				end
				if (iq_instr !== expected_word(iq_pc)) begin
					errors++;
					$display("ERR %0t: iq_instr %h for pc %h, expected %h", $time,
						iq_instr, iq_pc, expected_word(iq_pc));
				end
				if (!resident.exists(iq_pc >> 5)) begin
					errors++;
					$display("ERR %0t: word at %h from a line never refilled", $time, iq_pc);
				end
				// Resync so one slip reports once
				exp_pc = iq_pc + 32'd8;
			end
			// Read channel ready spans the open burst and nothing else
			if (in_burst && !mem_rready) begin
				errors++;
				$display("ERR %0t: mem_rready low during a burst", $time);
			end
			if (!in_burst && !mem_arvalid && mem_rready) begin
				errors++;
				$display("ERR %0t: mem_rready high with no refill open", $time);
			end
			if (mem_rvalid && mem_rready && mem_rlast) in_burst = 1'b0;
			if (mem_arvalid && mem_arready) begin
				refills++;
				in_burst = 1'b1;
				if (mem_araddr[4:0] != 5'd0) begin
					errors++;
					$display("ERR %0t: mem_araddr %h not line aligned", $time, mem_araddr);
				end
				if (resident.exists(mem_araddr >> 5)) begin
					errors++;
					$display("ERR %0t: refill of resident line %h", $time, mem_araddr);
				end
				resident[mem_araddr >> 5] = 1'b1;
			end
			if (fence_end) begin
				fence_ends++;
				resident.delete();
			end
			// Redirect applies after any word already on its way out
			if (flush) exp_pc = flush_pc;
		end
	end

	initial begin
		seed       = 32'hbf37_828e;
		flush      = 1'b0;
		flush_pc   = '0;
		fence      = 1'b0;
		iq_ready   = 1'b0;
		ready_mode = 2'd0;
		exp_pc     = `ICACHE_RESET_PC;
		waited     = 0;
		while (!rst_n) begin
			@(posedge CLK);
			waited++;
			if (waited > TIMEOUT) give_up("reset release");
		end
		foreach (rows[i]) begin
			@(posedge CLK);
			ready_mode = rows[i].mode;
			#1;
			if (rows[i].do_fence) begin
				fence = 1'b1;
				fences_sent++;
				waited = 0;
				do begin
					@(posedge CLK);
					waited++;
					if (waited > TIMEOUT) give_up("fence_end");
				end while (!fence_end);
				#1 fence = 1'b0;
			end
			if (rows[i].do_flush) begin
				waited = 0;
				// AR still pending, so the killed request has no word out yet
				while (rows[i].on_miss && !mem_arvalid) begin
					@(posedge CLK);
					#1;
					waited++;
					if (waited > TIMEOUT) give_up("a pending refill");
				end
				flush    = 1'b1;
				flush_pc = rows[i].target;
				@(posedge CLK);
				#1 flush = 1'b0;
			end
			first  = words;
			waited = 0;
			while (words < first + int'(rows[i].count)) begin
				@(posedge CLK);
				waited++;
				if (waited > TIMEOUT) give_up("queue words");
			end
			ready_mode = 2'd0;
		end
		repeat (20) @(posedge CLK);
		if (fence_ends != fences_sent) begin
			errors++;
			$display("ERR %0t: %0d fence_end pulses for %0d fences", $time,
				fence_ends, fences_sent);
		end
		$display("errors %0d, words %0d, refills %0d, fences %0d", errors, words, refills,
			fence_ends);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
src/icache_pkg.sv
src/victim_sel.sv
src/icache_mem.sv
src/icache.sv
src/pc_gen.sv
src/fetch_top.sv
test/tb_clk_gen.sv
test/tb_mem_model.sv
test/tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch front testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
